//--- design/eth_proto_pkg.sv
package eth_proto_pkg;

	// header sizes in bytes
	localparam int eth_head_len = 14;
	localparam int ip_head_len = 20;
	localparam int udp_head_len = 8;
	localparam int udp_stack_len = eth_head_len + ip_head_len + udp_head_len;

	// Ethernet header followed by the 28 byte ARP body
	localparam int arp_frame_len = 42;

	localparam logic [15:0] ethertype_ipv4 = 16'h0800;
	localparam logic [15:0] ethertype_arp = 16'h0806;

	// version 4 with a five word header
	localparam logic [7:0] ip_ver_ihl = 8'h45;
	localparam logic [7:0] ip_proto_udp = 8'd17;
	localparam logic [7:0] ip_ttl = 8'd128;

	// the endpoint talks from and to the same port
	localparam logic [15:0] udp_port = 16'hFEEF;

	// byte offsets counted from the first byte of the frame
	localparam logic [5:0] off_dst_mac = 6'd0;
	localparam logic [5:0] off_src_mac = 6'd6;
	localparam logic [5:0] off_ethertype = 6'd12;
	localparam logic [5:0] off_ip_src = 6'd26;
	localparam logic [5:0] off_arp_sender_mac = 6'd22;
	localparam logic [5:0] off_arp_sender_ip = 6'd28;

	localparam logic [15:0] arp_htype_eth = 16'd1;
	localparam logic [7:0] arp_hw_size = 8'd6;
	localparam logic [7:0] arp_proto_size = 8'd4;
	localparam logic [15:0] arp_op_reply = 16'd2;

endpackage

//--- design/commu_pkg.sv
package commu_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [47:0] mac_t;
	typedef logic [31:0] ip_t;
	typedef logic [10:0] len_t;

	localparam mac_t init_local_mac = 48'h02_00_00_00_00_04;
	localparam mac_t init_dest_mac = 48'h02_00_00_00_00_05;
	localparam ip_t init_local_ip = 32'hC0_A8_01_04;
	localparam ip_t init_dest_ip = 32'hC0_A8_01_05;

	localparam byte_t cmd_set_server = 8'd0;
	localparam byte_t cmd_set_local = 8'd1;

	// command byte, check byte and a 4 byte parameter
	localparam int cmd_len = 6;

	// 42 header bytes plus the command block are kept per frame
	localparam int rx_keep_len = 42 + cmd_len;
	localparam int rx_slots = 4;
	localparam int rx_slot_w = $clog2(rx_slots);
	localparam int rx_ram_depth = rx_slots * rx_keep_len;
	localparam int rx_ram_aw = $clog2(rx_ram_depth);

endpackage

//--- design/tx_frame_sender.sv
`timescale 1ns/10ps

module tx_frame_sender
(
	input logic i_clk,
	input logic i_rst_n,
	input logic i_trig_send,
	input commu_pkg::len_t i_data_length,
	input commu_pkg::byte_t i_pck_ident,
	input commu_pkg::byte_t i_pck_idx,
	input commu_pkg::byte_t i_cur_byte,
	input commu_pkg::ip_t i_local_ip,
	input commu_pkg::ip_t i_dest_ip,
	input commu_pkg::mac_t i_dest_mac,
	input logic i_arp_req,
	input commu_pkg::ip_t i_arp_ip,
	input commu_pkg::mac_t i_arp_mac,
	output logic o_get_cur_byte,
	output logic o_send_over,
	output logic o_tx_valid,
	output logic o_tx_last,
	output commu_pkg::byte_t o_tx_data
);

	typedef enum logic [2:0]
	{
		st_idle,
		st_head,
		st_ident,
		st_payload,
		st_done,
		st_arp
	} state_t;

	state_t state;
	logic trig_d;
	logic trig_edge;
	logic data_pend;
	logic arp_pend;
	logic take_data;
	logic take_arp;
	logic [5:0] head_cnt;
	commu_pkg::len_t pay_cnt;

	// addresses of the frame on the line, latched when its request is taken
	commu_pkg::mac_t peer_mac;
	commu_pkg::ip_t peer_ip;
	commu_pkg::ip_t own_ip;

	logic [15:0] ip_total_len;
	logic [15:0] udp_len;
	logic [19:0] csum_acc;
	logic [16:0] csum_fold;
	logic [15:0] ip_csum;
	logic [8*eth_proto_pkg::udp_stack_len-1:0] udp_head;
	logic [8*eth_proto_pkg::arp_frame_len-1:0] arp_head;

	assign trig_edge = i_trig_send && !trig_d;
	// a pending ARP reply always goes out before a data frame
	assign take_arp = (state == st_idle) && arp_pend;
	assign take_data = (state == st_idle) && data_pend && !arp_pend;

	// the identifier and index bytes count as UDP payload
	assign ip_total_len = 16'(eth_proto_pkg::ip_head_len + eth_proto_pkg::udp_head_len + 2)
		+ 16'(i_data_length);
	assign udp_len = 16'(eth_proto_pkg::udp_head_len + 2) + 16'(i_data_length);

	// identification, flags and checksum words are zero and drop out of the sum
	always_comb
	begin
		csum_acc = 20'({eth_proto_pkg::ip_ver_ihl, 8'h00}) + 20'(ip_total_len)
			+ 20'({eth_proto_pkg::ip_ttl, eth_proto_pkg::ip_proto_udp})
			+ 20'(own_ip[31:16]) + 20'(own_ip[15:0])
			+ 20'(peer_ip[31:16]) + 20'(peer_ip[15:0]);
		csum_fold = 17'(csum_acc[15:0]) + 17'(csum_acc[19:16]);
		ip_csum = ~(csum_fold[15:0] + 16'(csum_fold[16]));
	end

	assign udp_head =
	{
		peer_mac, commu_pkg::init_local_mac, eth_proto_pkg::ethertype_ipv4,
		eth_proto_pkg::ip_ver_ihl, 8'h00, ip_total_len, 32'h0,
		eth_proto_pkg::ip_ttl, eth_proto_pkg::ip_proto_udp, ip_csum, own_ip, peer_ip,
		eth_proto_pkg::udp_port, eth_proto_pkg::udp_port, udp_len, 16'h0000
	};

	assign arp_head =
	{
		peer_mac, commu_pkg::init_local_mac, eth_proto_pkg::ethertype_arp,
		eth_proto_pkg::arp_htype_eth, eth_proto_pkg::ethertype_ipv4,
		eth_proto_pkg::arp_hw_size, eth_proto_pkg::arp_proto_size, eth_proto_pkg::arp_op_reply,
		commu_pkg::init_local_mac, own_ip, peer_mac, peer_ip
	};

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= st_idle;
			trig_d <= 1'b0;
			data_pend <= 1'b0;
			arp_pend <= 1'b0;
			head_cnt <= '0;
			pay_cnt <= '0;
			o_tx_valid <= 1'b0;
			o_tx_last <= 1'b0;
			o_get_cur_byte <= 1'b0;
			o_send_over <= 1'b0;
		end
		else
		begin
			trig_d <= i_trig_send;
			data_pend <= trig_edge || (data_pend && !take_data);
			arp_pend <= i_arp_req || (arp_pend && !take_arp);
			o_tx_valid <= 1'b0;
			o_tx_last <= 1'b0;
			o_get_cur_byte <= 1'b0;
			o_send_over <= 1'b0;
			case (state)
				st_idle:
				begin
					head_cnt <= '0;
					if (take_arp)
						state <= st_arp;
					else if (take_data)
						state <= st_head;
				end
				st_head:
				begin
					o_tx_valid <= 1'b1;
					head_cnt <= head_cnt + 6'd1;
					if (head_cnt == 6'(eth_proto_pkg::udp_stack_len - 1))
					begin
						head_cnt <= '0;
						state <= st_ident;
					end
				end
				st_ident:
				begin
					o_tx_valid <= 1'b1;
					head_cnt <= head_cnt + 6'd1;
					pay_cnt <= 11'd1;
					if (head_cnt == 6'd1)
					begin
						if (i_data_length == '0)
						begin
							o_tx_last <= 1'b1;
							state <= st_done;
						end
						else
							state <= st_payload;
					end
				end
				st_payload:
				begin
					o_tx_valid <= 1'b1;
					o_get_cur_byte <= 1'b1;
					pay_cnt <= pay_cnt + 11'd1;
					if (pay_cnt == i_data_length)
					begin
						o_tx_last <= 1'b1;
						state <= st_done;
					end
				end
				st_done:
				begin
					o_send_over <= 1'b1;
					state <= st_idle;
				end
				st_arp:
				begin
					o_tx_valid <= 1'b1;
					head_cnt <= head_cnt + 6'd1;
					if (head_cnt == 6'(eth_proto_pkg::arp_frame_len - 1))
					begin
						o_tx_last <= 1'b1;
						state <= st_idle;
					end
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (take_arp)
		begin
			peer_mac <= i_arp_mac;
			peer_ip <= i_arp_ip;
			own_ip <= i_local_ip;
		end
		else if (take_data)
		begin
			peer_mac <= i_dest_mac;
			peer_ip <= i_dest_ip;
			own_ip <= i_local_ip;
		end

		case (state)
			st_head:
				o_tx_data <= udp_head[8*(eth_proto_pkg::udp_stack_len-1-int'(head_cnt)) +: 8];
			st_ident:
				o_tx_data <= (head_cnt == 6'd0) ? i_pck_ident : i_pck_idx;
			st_payload:
				o_tx_data <= i_cur_byte;
			st_arp:
				o_tx_data <= arp_head[8*(eth_proto_pkg::arp_frame_len-1-int'(head_cnt)) +: 8];
			default:
				o_tx_data <= '0;
		endcase
	end

endmodule

//--- design/rx_frame_buffer.sv
`timescale 1ns/10ps

module rx_frame_buffer
(
	input logic i_clk,
	input logic i_rst_n,
	input logic i_rx_dv,
	input commu_pkg::byte_t i_rx_data,
	input logic [5:0] i_slot_addr,
	input logic i_slot_release,
	output logic o_slot_valid,
	output commu_pkg::byte_t o_slot_byte
);

	typedef logic [commu_pkg::rx_ram_aw-1:0] ram_addr_t;

	commu_pkg::byte_t ram [commu_pkg::rx_ram_depth];

	// the top bit tells a full ring from an empty one
	logic [commu_pkg::rx_slot_w:0] wr_slot;
	logic [commu_pkg::rx_slot_w:0] rd_slot;
	logic [5:0] wr_cnt;
	logic rx_dv_d;
	logic capture;
	logic frame_start;
	logic frame_end;
	logic accept;
	logic full;
	logic empty;
	logic wr_en;
	ram_addr_t wr_addr;
	ram_addr_t rd_addr;

	assign frame_start = i_rx_dv && !rx_dv_d;
	assign frame_end = !i_rx_dv && rx_dv_d;
	assign empty = (wr_slot == rd_slot);
	assign full = (wr_slot[commu_pkg::rx_slot_w] != rd_slot[commu_pkg::rx_slot_w])
		&& (wr_slot[commu_pkg::rx_slot_w-1:0] == rd_slot[commu_pkg::rx_slot_w-1:0]);

	// a frame is taken or refused as a whole on its first byte
	assign accept = frame_start ? !full : capture;
	assign wr_en = i_rx_dv && accept && (wr_cnt < 6'(commu_pkg::rx_keep_len));

	assign wr_addr = ram_addr_t'(wr_slot[commu_pkg::rx_slot_w-1:0])
		* ram_addr_t'(commu_pkg::rx_keep_len) + ram_addr_t'(wr_cnt);
	assign rd_addr = ram_addr_t'(rd_slot[commu_pkg::rx_slot_w-1:0])
		* ram_addr_t'(commu_pkg::rx_keep_len) + ram_addr_t'(i_slot_addr);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			rx_dv_d <= 1'b0;
			capture <= 1'b0;
			wr_cnt <= '0;
			wr_slot <= '0;
			rd_slot <= '0;
		end
		else
		begin
			rx_dv_d <= i_rx_dv;
			if (frame_start)
				capture <= !full;
			if (wr_en)
				wr_cnt <= wr_cnt + 6'd1;
			if (frame_end)
			begin
				capture <= 1'b0;
				wr_cnt <= '0;
				if (capture)
					wr_slot <= wr_slot + 1'b1;
			end
			if (i_slot_release && !empty)
				rd_slot <= rd_slot + 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (wr_en)
			ram[wr_addr] <= i_rx_data;
	end

	assign o_slot_valid = !empty;
	assign o_slot_byte = ram[rd_addr];

endmodule

//--- design/rx_cmd_parser.sv
`timescale 1ns/10ps

module rx_cmd_parser
(
	input logic i_clk,
	input logic i_rst_n,
	input logic i_slot_valid,
	input commu_pkg::byte_t i_slot_byte,
	output logic [5:0] o_slot_addr,
	output logic o_slot_release,
	output commu_pkg::ip_t o_local_ip,
	output commu_pkg::ip_t o_dest_ip,
	output commu_pkg::mac_t o_dest_mac,
	output logic o_arp_req,
	output commu_pkg::ip_t o_arp_ip,
	output commu_pkg::mac_t o_arp_mac,
	output commu_pkg::byte_t o_cmd,
	output logic [31:0] o_param,
	output logic o_cmd_come
);

	typedef enum logic [1:0]
	{
		st_idle,
		st_load,
		st_decide
	} state_t;

	state_t state;
	// the first stored byte ends up in the top byte after the walk
	logic [8*commu_pkg::rx_keep_len-1:0] frame_q;
	commu_pkg::mac_t rx_dst_mac;
	commu_pkg::mac_t rx_src_mac;
	commu_pkg::mac_t rx_arp_mac;
	logic [15:0] rx_ethertype;
	commu_pkg::ip_t rx_ip_src;
	commu_pkg::ip_t rx_arp_ip;
	commu_pkg::byte_t rx_cmd;
	commu_pkg::byte_t rx_check;
	logic [31:0] rx_param;
	logic mac_ok;
	logic do_arp;
	logic do_cmd;

	function automatic int field_lsb(input int offset, input int len);
		return 8 * (commu_pkg::rx_keep_len - offset - len);
	endfunction

	assign rx_dst_mac = frame_q[field_lsb(eth_proto_pkg::off_dst_mac, 6) +: 48];
	assign rx_src_mac = frame_q[field_lsb(eth_proto_pkg::off_src_mac, 6) +: 48];
	assign rx_ethertype = frame_q[field_lsb(eth_proto_pkg::off_ethertype, 2) +: 16];
	assign rx_ip_src = frame_q[field_lsb(eth_proto_pkg::off_ip_src, 4) +: 32];
	assign rx_arp_mac = frame_q[field_lsb(eth_proto_pkg::off_arp_sender_mac, 6) +: 48];
	assign rx_arp_ip = frame_q[field_lsb(eth_proto_pkg::off_arp_sender_ip, 4) +: 32];
	// the command block sits right behind the UDP header
	assign rx_cmd = frame_q[field_lsb(eth_proto_pkg::udp_stack_len, 1) +: 8];
	assign rx_check = frame_q[field_lsb(eth_proto_pkg::udp_stack_len + 1, 1) +: 8];
	assign rx_param = frame_q[field_lsb(eth_proto_pkg::udp_stack_len + 2, 4) +: 32];

	assign mac_ok = (rx_dst_mac == commu_pkg::init_local_mac) || (&rx_dst_mac);
	assign do_arp = (state == st_decide) && mac_ok
		&& (rx_ethertype == eth_proto_pkg::ethertype_arp);
	assign do_cmd = (state == st_decide) && mac_ok
		&& (rx_ethertype == eth_proto_pkg::ethertype_ipv4) && (rx_check == ~rx_cmd);

	// every frame leaves through the decide state, so every path frees its slot
	assign o_slot_release = (state == st_decide);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= st_idle;
			o_slot_addr <= '0;
			o_local_ip <= commu_pkg::init_local_ip;
			o_dest_ip <= commu_pkg::init_dest_ip;
			o_dest_mac <= commu_pkg::init_dest_mac;
			o_arp_req <= 1'b0;
			o_cmd_come <= 1'b0;
		end
		else
		begin
			o_arp_req <= do_arp;
			o_cmd_come <= 1'b0;
			case (state)
				st_idle:
					if (i_slot_valid)
						state <= st_load;
				st_load:
				begin
					o_slot_addr <= o_slot_addr + 6'd1;
					if (o_slot_addr == 6'(commu_pkg::rx_keep_len - 1))
						state <= st_decide;
				end
				st_decide:
				begin
					o_slot_addr <= '0;
					state <= st_idle;
				end
				default:
					state <= st_idle;
			endcase
			if (do_cmd)
			begin
				if (rx_cmd == commu_pkg::cmd_set_local)
					o_local_ip <= rx_param;
				else if (rx_cmd == commu_pkg::cmd_set_server)
				begin
					o_dest_ip <= rx_ip_src;
					o_dest_mac <= rx_src_mac;
				end
				else
					o_cmd_come <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (state == st_load)
			frame_q <= {frame_q[8*(commu_pkg::rx_keep_len-1)-1:0], i_slot_byte};
		if (do_arp)
		begin
			o_arp_ip <= rx_arp_ip;
			o_arp_mac <= rx_arp_mac;
		end
		if (do_cmd)
		begin
			o_cmd <= rx_cmd;
			o_param <= rx_param;
		end
	end

endmodule

//--- design/eth_commu_top.sv
`timescale 1ns/10ps

module eth_commu_top
(
	input logic i_clk,
	input logic i_rst_n,
	input logic i_trig_send,
	input commu_pkg::len_t i_data_length,
	input commu_pkg::byte_t i_pck_ident,
	input commu_pkg::byte_t i_pck_idx,
	input commu_pkg::byte_t i_cur_byte,
	output logic o_get_cur_byte,
	output logic o_send_over,
	output logic o_tx_valid,
	output logic o_tx_last,
	output commu_pkg::byte_t o_tx_data,
	input logic i_rx_dv,
	input commu_pkg::byte_t i_rx_data,
	output commu_pkg::byte_t o_cmd,
	output logic [31:0] o_param,
	output logic o_cmd_come
);

	commu_pkg::ip_t local_ip;
	commu_pkg::ip_t dest_ip;
	commu_pkg::mac_t dest_mac;
	logic arp_req;
	commu_pkg::ip_t arp_ip;
	commu_pkg::mac_t arp_mac;

	logic slot_valid;
	commu_pkg::byte_t slot_byte;
	logic [5:0] slot_addr;
	logic slot_release;

	tx_frame_sender u_sender
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_trig_send(i_trig_send),
		.i_data_length(i_data_length),
		.i_pck_ident(i_pck_ident),
		.i_pck_idx(i_pck_idx),
		.i_cur_byte(i_cur_byte),
		.i_local_ip(local_ip),
		.i_dest_ip(dest_ip),
		.i_dest_mac(dest_mac),
		.i_arp_req(arp_req),
		.i_arp_ip(arp_ip),
		.i_arp_mac(arp_mac),
		.o_get_cur_byte(o_get_cur_byte),
		.o_send_over(o_send_over),
		.o_tx_valid(o_tx_valid),
		.o_tx_last(o_tx_last),
		.o_tx_data(o_tx_data)
	);

	rx_frame_buffer u_rx_buf
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_rx_dv(i_rx_dv),
		.i_rx_data(i_rx_data),
		.i_slot_addr(slot_addr),
		.i_slot_release(slot_release),
		.o_slot_valid(slot_valid),
		.o_slot_byte(slot_byte)
	);

	rx_cmd_parser u_parser
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_slot_valid(slot_valid),
		.i_slot_byte(slot_byte),
		.o_slot_addr(slot_addr),
		.o_slot_release(slot_release),
		.o_local_ip(local_ip),
		.o_dest_ip(dest_ip),
		.o_dest_mac(dest_mac),
		.o_arp_req(arp_req),
		.o_arp_ip(arp_ip),
		.o_arp_mac(arp_mac),
		.o_cmd(o_cmd),
		.o_param(o_param),
		.o_cmd_come(o_cmd_come)
	);

endmodule

//--- testbench/eth_commu_assertions.sv
`timescale 1ns/10ps

module eth_commu_assertions
(
	input logic i_clk,
	input logic i_rst_n,
	input logic i_tx_valid,
	input logic i_tx_last,
	input logic i_get_cur_byte,
	input logic i_send_over,
	input logic i_cmd_come
);

	// the final byte of a frame is always a valid byte
	last_in_frame: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_tx_last |-> i_tx_valid)
		else $error("o_tx_last was high while o_tx_valid was low");

	// the MAC has no back-pressure, so a frame may not have holes
	frame_unbroken: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_tx_valid && !i_tx_last |=> i_tx_valid)
		else $error("o_tx_valid dropped before o_tx_last");

	// payload is only pulled while its byte goes out
	pull_in_frame: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_get_cur_byte |-> i_tx_valid)
		else $error("o_get_cur_byte was high outside a frame");

	cmd_come_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_cmd_come |=> !i_cmd_come)
		else $error("o_cmd_come stayed high for two cycles");

	send_over_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_send_over |=> !i_send_over)
		else $error("o_send_over stayed high for two cycles");

endmodule

bind eth_commu_top eth_commu_assertions u_assertions
(
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.i_tx_valid(o_tx_valid),
	.i_tx_last(o_tx_last),
	.i_get_cur_byte(o_get_cur_byte),
	.i_send_over(o_send_over),
	.i_cmd_come(o_cmd_come)
);

//--- testbench/tb_eth_commu.sv
`timescale 1ns/10ps

module tb_eth_commu;

	localparam int num_tests = 7;
	localparam int cap_limit = 400;

	logic i_clk;
	logic i_rst_n;
	logic i_trig_send;
	commu_pkg::len_t i_data_length;
	commu_pkg::byte_t i_pck_ident;
	commu_pkg::byte_t i_pck_idx;
	commu_pkg::byte_t i_cur_byte;
	logic o_get_cur_byte;
	logic o_send_over;
	logic o_tx_valid;
	logic o_tx_last;
	commu_pkg::byte_t o_tx_data;
	logic i_rx_dv;
	commu_pkg::byte_t i_rx_data;
	commu_pkg::byte_t o_cmd;
	logic [31:0] o_param;
	logic o_cmd_come;

	commu_pkg::byte_t build_q[$];
	commu_pkg::byte_t cap_q[$];
	commu_pkg::byte_t data_cap[$];
	commu_pkg::byte_t payload[$];
	logic [31:0] lcg_state = 32'he4ec_d6d4;
	int val_errs = 0;
	int other_errs = 0;
	int cmd_pulses = 0;

	eth_commu_top UUT
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_trig_send(i_trig_send),
		.i_data_length(i_data_length),
		.i_pck_ident(i_pck_ident),
		.i_pck_idx(i_pck_idx),
		.i_cur_byte(i_cur_byte),
		.o_get_cur_byte(o_get_cur_byte),
		.o_send_over(o_send_over),
		.o_tx_valid(o_tx_valid),
		.o_tx_last(o_tx_last),
		.o_tx_data(o_tx_data),
		.i_rx_dv(i_rx_dv),
		.i_rx_data(i_rx_data),
		.o_cmd(o_cmd),
		.o_param(o_param),
		.o_cmd_come(o_cmd_come)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	initial
	begin
		#(num_tests * 200 * 10);
		$display("the run timed out after %0d clock cycles", num_tests * 200);
		$display("tests failed");
		$finish;
	end

	always @(negedge i_clk)
	begin
		if (o_cmd_come)
			cmd_pulses++;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic void put_vec(input logic [383:0] v, input int n);
		for (int i = n - 1; i >= 0; i--)
			build_q.push_back(v[8*i +: 8]);
	endfunction

	// ones' complement sum of the ten IPv4 header words
	function automatic logic [15:0] header_sum(input commu_pkg::byte_t q[$]);
		logic [31:0] s;
		s = '0;
		for (int i = 0; i < 10; i++)
			s = s + 32'({q[eth_proto_pkg::eth_head_len + 2*i],
				q[eth_proto_pkg::eth_head_len + 2*i + 1]});
		s = 32'(s[15:0]) + 32'(s[31:16]);
		s = 32'(s[15:0]) + 32'(s[31:16]);
		return s[15:0];
	endfunction

	function automatic void build_data_frame(input commu_pkg::mac_t dst_mac,
		input commu_pkg::ip_t dst_ip, input commu_pkg::ip_t src_ip, input int len);
		logic [15:0] csum;
		build_q.delete();
		put_vec(384'({dst_mac, commu_pkg::init_local_mac, eth_proto_pkg::ethertype_ipv4,
			8'h45, 8'h00, 16'(30 + len), 32'h0, eth_proto_pkg::ip_ttl,
			eth_proto_pkg::ip_proto_udp, 16'h0000, src_ip, dst_ip, eth_proto_pkg::udp_port,
			eth_proto_pkg::udp_port, 16'(10 + len), 16'h0000}), 42);
		csum = ~header_sum(build_q);
		build_q[24] = csum[15:8];
		build_q[25] = csum[7:0];
		build_q.push_back(i_pck_ident);
		build_q.push_back(i_pck_idx);
		foreach (payload[i])
			build_q.push_back(payload[i]);
	endfunction

	function automatic void build_cmd_frame(input commu_pkg::mac_t dst_mac,
		input commu_pkg::mac_t src_mac, input commu_pkg::ip_t src_ip,
		input commu_pkg::byte_t cmd, input commu_pkg::byte_t check, input logic [31:0] param);
		build_q.delete();
		put_vec({dst_mac, src_mac, eth_proto_pkg::ethertype_ipv4, 8'h45, 8'h00, 16'd34,
			32'h0, eth_proto_pkg::ip_ttl, eth_proto_pkg::ip_proto_udp, 16'h0000, src_ip,
			commu_pkg::init_local_ip, eth_proto_pkg::udp_port, eth_proto_pkg::udp_port,
			16'd14, 16'h0000, cmd, check, param}, 48);
	endfunction

	function automatic void build_arp_request(input commu_pkg::mac_t req_mac,
		input commu_pkg::ip_t req_ip, input commu_pkg::ip_t target_ip);
		build_q.delete();
		put_vec(384'({48'hFFFF_FFFF_FFFF, req_mac, eth_proto_pkg::ethertype_arp, 16'h0001,
			16'h0800, 8'h06, 8'h04, 16'h0001, req_mac, req_ip, 48'h0, target_ip}), 42);
	endfunction

	function automatic void build_arp_reply(input commu_pkg::mac_t req_mac,
		input commu_pkg::ip_t req_ip, input commu_pkg::ip_t own_ip);
		build_q.delete();
		put_vec(384'({req_mac, commu_pkg::init_local_mac, eth_proto_pkg::ethertype_arp,
			16'h0001, 16'h0800, 8'h06, 8'h04, eth_proto_pkg::arp_op_reply,
			commu_pkg::init_local_mac, own_ip, req_mac, req_ip}), 42);
	endfunction

	task automatic expect_value(input logic [47:0] got, input logic [47:0] exp,
		input string what);
		assert (got === exp)
		else
		begin
			val_errs++;
			$display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic sync_drive();
		@(posedge i_clk);
		#1;
	endtask

	task automatic send_rx_frame();
		foreach (build_q[i])
		begin
			i_rx_dv = 1'b1;
			i_rx_data = build_q[i];
			sync_drive();
		end
		i_rx_dv = 1'b0;
		i_rx_data = '0;
		sync_drive();
	endtask

	task automatic capture_frame();
		int n;
		bit done;
		cap_q.delete();
		n = 0;
		done = 1'b0;
		do
		begin
			@(negedge i_clk);
			n++;
		end
		while (!o_tx_valid && n < cap_limit);
		if (!o_tx_valid)
		begin
			other_errs++;
			$display("no frame appeared on o_tx_valid in time");
			return;
		end
		while (o_tx_valid && !done)
		begin
			cap_q.push_back(o_tx_data);
			done = o_tx_last;
			if (!done)
				@(negedge i_clk);
		end
	endtask

	task automatic wait_cmd_come();
		int n;
		n = 0;
		do
		begin
			@(negedge i_clk);
			n++;
		end
		while (!o_cmd_come && n < cap_limit);
		if (!o_cmd_come)
		begin
			other_errs++;
			$display("no o_cmd_come pulse arrived in time");
		end
		// lets the pulse counter settle before it is read
		@(negedge i_clk);
		sync_drive();
	endtask

	// a user command behind other frames shows that the parser has handled them
	task automatic flush_parser();
		build_cmd_frame(commu_pkg::init_local_mac, commu_pkg::init_dest_mac,
			commu_pkg::init_dest_ip, 8'h5A, 8'hA5, 32'h0);
		send_rx_frame();
		wait_cmd_come();
	endtask

	task automatic compare_frame(input commu_pkg::byte_t got[$], input string what);
		expect_value(48'(got.size()), 48'(build_q.size()), {what, " length"});
		for (int i = 0; i < build_q.size() && i < got.size(); i++)
			expect_value(48'(got[i]), 48'(build_q[i]), $sformatf("%s byte %0d", what, i));
	endtask

	task automatic send_data_frame(input int len, input bit with_arp);
		int idx;
		int n;
		payload.delete();
		for (int i = 0; i < len; i++)
			payload.push_back(commu_pkg::byte_t'(next_rand() >> 24));
		i_pck_ident = commu_pkg::byte_t'(next_rand() >> 24);
		i_pck_idx = commu_pkg::byte_t'(next_rand() >> 24);
		i_data_length = commu_pkg::len_t'(len);
		i_cur_byte = payload[0];
		i_trig_send = 1'b1;
		sync_drive();
		i_trig_send = 1'b0;
		fork
			begin
				idx = 0;
				n = 0;
				while (!o_send_over && n < cap_limit)
				begin
					sync_drive();
					n++;
					if (o_get_cur_byte)
					begin
						idx++;
						if (idx < len)
							i_cur_byte = payload[idx];
					end
				end
				if (!o_send_over)
				begin
					other_errs++;
					$display("o_send_over did not pulse after the data frame");
				end
			end
			begin
				capture_frame();
				data_cap = cap_q;
				if (with_arp)
					capture_frame();
			end
		join
		sync_drive();
	endtask

	task automatic check_data_frame(input commu_pkg::mac_t dst_mac, input commu_pkg::ip_t dst_ip,
		input commu_pkg::ip_t src_ip, input int len, input string what);
		build_data_frame(dst_mac, dst_ip, src_ip, len);
		compare_frame(data_cap, what);
		if (data_cap.size() >= 34)
			expect_value(48'(header_sum(data_cap)), 48'hFFFF, {what, " IP header sum"});
	endtask

	initial
	begin
		logic [31:0] param;
		int base;
		int len;
		commu_pkg::mac_t req_mac;
		commu_pkg::ip_t req_ip;

		i_rst_n = 1'b0;
		i_trig_send = 1'b0;
		i_data_length = '0;
		i_pck_ident = '0;
		i_pck_idx = '0;
		i_cur_byte = '0;
		i_rx_dv = 1'b0;
		i_rx_data = '0;

		@(negedge i_clk);
		expect_value(48'({o_tx_valid, o_tx_last, o_get_cur_byte, o_send_over, o_cmd_come}),
			48'd0, "control outputs during reset");
		repeat (2) @(posedge i_clk);
		#1 i_rst_n = 1'b1;
		@(negedge i_clk);
		expect_value(48'({o_tx_valid, o_tx_last, o_get_cur_byte, o_send_over, o_cmd_come}),
			48'd0, "control outputs after reset");
		sync_drive();

		len = 1 + int'((next_rand() >> 16) % 24);
		send_data_frame(len, 1'b0);
		check_data_frame(commu_pkg::init_dest_mac, commu_pkg::init_dest_ip,
			commu_pkg::init_local_ip, len, "first data frame");

		// bad check byte and foreign MAC go ahead of the good command and carry another parameter
		param = next_rand();
		base = cmd_pulses;
		build_cmd_frame(commu_pkg::init_local_mac, commu_pkg::init_dest_mac,
			commu_pkg::init_dest_ip, 8'h23, 8'hDD, ~param);
		send_rx_frame();
		build_cmd_frame(48'h02_00_00_00_00_77, commu_pkg::init_dest_mac,
			commu_pkg::init_dest_ip, 8'h23, 8'hDC, ~param);
		send_rx_frame();
		build_cmd_frame(commu_pkg::init_local_mac, commu_pkg::init_dest_mac,
			commu_pkg::init_dest_ip, 8'h23, 8'hDC, param);
		send_rx_frame();
		wait_cmd_come();
		expect_value(48'(cmd_pulses - base), 48'd1, "o_cmd_come pulse count");
		expect_value(48'(o_cmd), 48'h23, "o_cmd");
		expect_value(48'(o_param), 48'(param), "o_param");

		build_cmd_frame(commu_pkg::init_local_mac, 48'h02_00_00_00_00_09, 32'hC0A8_0109,
			commu_pkg::cmd_set_server, ~commu_pkg::cmd_set_server, next_rand());
		send_rx_frame();
		flush_parser();
		len = 1 + int'((next_rand() >> 16) % 24);
		send_data_frame(len, 1'b0);
		check_data_frame(48'h02_00_00_00_00_09, 32'hC0A8_0109, commu_pkg::init_local_ip, len,
			"frame after set_server");

		build_cmd_frame(commu_pkg::init_local_mac, commu_pkg::init_dest_mac,
			commu_pkg::init_dest_ip, commu_pkg::cmd_set_local, ~commu_pkg::cmd_set_local,
			32'hC0A8_0177);
		send_rx_frame();
		flush_parser();
		len = 1 + int'((next_rand() >> 16) % 24);
		send_data_frame(len, 1'b0);
		check_data_frame(48'h02_00_00_00_00_09, 32'hC0A8_0109, 32'hC0A8_0177, len,
			"frame after set_local");

		req_mac = {16'h0200, next_rand()};
		req_ip = {16'hC0A8, 16'(next_rand() >> 16)};
		build_arp_request(req_mac, req_ip, 32'hC0A8_0177);
		send_rx_frame();
		capture_frame();
		sync_drive();
		build_arp_reply(req_mac, req_ip, 32'hC0A8_0177);
		compare_frame(cap_q, "ARP reply");

		// this request is parsed while the long data frame is on the line
		req_mac = {16'h0200, next_rand()};
		req_ip = {16'hC0A8, 16'(next_rand() >> 16)};
		build_arp_request(req_mac, req_ip, 32'hC0A8_0177);
		send_rx_frame();
		send_data_frame(56, 1'b1);
		build_arp_reply(req_mac, req_ip, 32'hC0A8_0177);
		compare_frame(cap_q, "ARP reply after data frame");
		check_data_frame(48'h02_00_00_00_00_09, 32'hC0A8_0109, 32'hC0A8_0177, 56,
			"data frame ahead of ARP reply");

		$display("value errors: %0d, other failures: %0d", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- files.f
design/eth_proto_pkg.sv
design/commu_pkg.sv
design/tx_frame_sender.sv
design/rx_frame_buffer.sv
design/rx_cmd_parser.sv
design/eth_commu_top.sv
testbench/eth_commu_assertions.sv
testbench/tb_eth_commu.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_eth_commu -f files.f
./obj_dir/Vtb_eth_commu | tee sim.log

if grep -q "all tests passed" sim.log
then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1
